//--- common/geom_pkg.sv
/*
	geometry package
	shared types and constants for the blanking trimmer and
	screen-geometry monitor, covering pixel and line counts,
	keyboard event codes and register reset values
*/
package geom_pkg;

	// pixel or line count, also used for margins and sizes
	typedef logic [11:0] coord_t;

	typedef logic [1:0] res_t;      // resolution code from the source
	typedef logic [6:0] flag_t;     // wrapping change counter

	// keyboard event as delivered with each level toggle
	typedef logic [1:0] kbd_type_t;
	typedef logic [7:0] kbd_code_t;

	localparam kbd_type_t kbd_type_key = 2'd3;

	// cursor block and backspace
	localparam kbd_code_t key_backspace = 8'h41;
	localparam kbd_code_t key_up        = 8'h4c;
	localparam kbd_code_t key_down      = 8'h4d;
	localparam kbd_code_t key_left      = 8'h4f;
	localparam kbd_code_t key_right     = 8'h4e;

	// alt press and release, left and right keys
	localparam kbd_code_t key_alt_press_l = 8'h64;
	localparam kbd_code_t key_alt_press_r = 8'h65;
	localparam kbd_code_t key_alt_rel_l   = 8'hE4;
	localparam kbd_code_t key_alt_rel_r   = 8'hE5;

	// register reset values
	localparam coord_t coord_rst = 12'd0;
	localparam res_t   res_rst   = 2'd0;
	localparam flag_t  flag_rst  = 7'd0;

endpackage

//--- src/trim_keys.sv
/*
	blanking margin keys
	turns keyboard events into the four blanking margins. cursor keys
	nudge top or left margin, with alt held the bottom or right one.
	backspace clears all four, a preset load overwrites them.
*/
`timescale 1ns/100ps

module trim_keys #(
	parameter int h_step = 4
) (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                kbd_level,
	input  geom_pkg::kbd_type_t kbd_type,
	input  geom_pkg::kbd_code_t kbd_data,
	input  logic                preset_load,
	input  geom_pkg::coord_t    preset_hbl_l,
	input  geom_pkg::coord_t    preset_hbl_r,
	input  geom_pkg::coord_t    preset_vbl_t,
	input  geom_pkg::coord_t    preset_vbl_b,
	output geom_pkg::coord_t    hbl_l,
	output geom_pkg::coord_t    hbl_r,
	output geom_pkg::coord_t    vbl_t,
	output geom_pkg::coord_t    vbl_b
);

	localparam geom_pkg::coord_t h_inc = geom_pkg::coord_t'(h_step);

	logic                level_q, level_qq;
	logic                load_q;
	logic                alt;
	logic                key_evt;
	geom_pkg::kbd_type_t type_q;
	geom_pkg::kbd_code_t data_q;
	geom_pkg::coord_t    pre_hbl_l, pre_hbl_r, pre_vbl_t, pre_vbl_b;

	// a toggle seen in the input stage, keyboard events only
	assign key_evt = (level_q ^ level_qq) && (type_q == geom_pkg::kbd_type_key);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_q  <= 1'b0;
			level_qq <= 1'b0;
			load_q   <= 1'b0;
		end else begin
			level_q  <= kbd_level;
			level_qq <= level_q;
			load_q   <= preset_load;
		end
	end

	// event payload, travels with the level stage
	always_ff @(posedge clk_sys) begin
		type_q    <= kbd_type;
		data_q    <= kbd_data;
		pre_hbl_l <= preset_hbl_l;
		pre_hbl_r <= preset_hbl_r;
		pre_vbl_t <= preset_vbl_t;
		pre_vbl_b <= preset_vbl_b;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hbl_l <= geom_pkg::coord_rst;
			hbl_r <= geom_pkg::coord_rst;
			vbl_t <= geom_pkg::coord_rst;
			vbl_b <= geom_pkg::coord_rst;
			alt   <= 1'b0;
		end else begin
			if (key_evt) begin
				case (data_q)
					geom_pkg::key_backspace: begin
						hbl_l <= geom_pkg::coord_rst;
						hbl_r <= geom_pkg::coord_rst;
						vbl_t <= geom_pkg::coord_rst;
						vbl_b <= geom_pkg::coord_rst;
					end
					geom_pkg::key_up:    if (alt) vbl_b <= vbl_b + 12'd1; else vbl_t <= vbl_t + 12'd1;
					geom_pkg::key_down:  if (alt) vbl_b <= vbl_b - 12'd1; else vbl_t <= vbl_t - 12'd1;
					geom_pkg::key_left:  if (alt) hbl_r <= hbl_r + h_inc; else hbl_l <= hbl_l + h_inc;
					geom_pkg::key_right: if (alt) hbl_r <= hbl_r - h_inc; else hbl_l <= hbl_l - h_inc;
					geom_pkg::key_alt_press_l, geom_pkg::key_alt_press_r: alt <= 1'b1;
					geom_pkg::key_alt_rel_l, geom_pkg::key_alt_rel_r:     alt <= 1'b0;
					default: ;
				endcase
			end
			// preset overrides any key in the same cycle
			if (load_q) begin
				hbl_l <= pre_hbl_l;
				hbl_r <= pre_hbl_r;
				vbl_t <= pre_vbl_t;
				vbl_b <= pre_vbl_b;
			end
		end
	end

	// event type must be defined once the source is out of reset
	kbd_type_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(kbd_type));

endmodule

//--- video/h_blank_gen.sv
/*
	horizontal blank generator
	counts pixels per line, records where active video starts and ends
	and where the line ends. builds the trimmed and the forced horizontal
	blank and measures the active width on the first line of field 0.
*/
`timescale 1ns/100ps

module h_blank_gen #(
	parameter int force_margin = 8,
	parameter int trim_lead    = 2
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             hs,
	input  logic             hblank,
	input  logic             field1,
	input  logic             line_one,
	input  geom_pkg::coord_t hbl_l,
	input  geom_pkg::coord_t hbl_r,
	output logic             hbl,
	output logic             hcnt_zero_line,
	output geom_pkg::coord_t hsize
);

	localparam geom_pkg::coord_t fmargin = geom_pkg::coord_t'(force_margin);
	localparam geom_pkg::coord_t lead    = geom_pkg::coord_t'(trim_lead);

	logic             old_hs, old_hblank;
	logic             act_start, act_end;
	logic             shbl, fhbl;
	geom_pkg::coord_t hcnt, hend, hsta, hmax;

	assign act_start      = old_hblank & ~hblank;
	assign act_end        = ~old_hblank & hblank;
	assign hcnt_zero_line = old_hs & ~hs;  // sync falling edge
	assign hbl            = fhbl | shbl | ~hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b1;
			hcnt       <= geom_pkg::coord_rst;
			hend       <= geom_pkg::coord_rst;
			hsta       <= geom_pkg::coord_rst;
			hmax       <= geom_pkg::coord_rst;
			hsize      <= geom_pkg::coord_rst;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			hcnt <= hs ? hcnt + 12'd1 : geom_pkg::coord_rst;

			if (act_start)      hend <= hcnt;
			if (act_end)        hsta <= hcnt;
			if (hcnt_zero_line) hmax <= hcnt;  // full line length

			// trimmed window, opened a little early to match the pipeline
			if (hcnt == hend + hbl_l - lead) shbl <= 1'b0;
			if (hcnt == hsta + hbl_r - lead) shbl <= 1'b1;

			// forced margins at both ends of the line
			if (hcnt == fmargin)        fhbl <= 1'b0;
			if (hcnt == hmax - fmargin) fhbl <= 1'b1;

			if (act_end && !field1 && line_one)
				hsize <= hcnt - hend;
		end
	end

	hcnt_restart: assert property (@(posedge clk_sys) disable iff (reset)
		!hs |=> hcnt == geom_pkg::coord_rst);

endmodule

//--- video/v_blank_gen.sv
/*
	vertical blank generator
	counts lines, records the active start, the frame end and the end of
	vertical sync. in interlaced mode the odd field's active height is
	added to vsize. builds trimmed and forced vertical blank, where a
	bottom margin with its top bit set counts back from the frame end.
	also registers the horizontal display enable.
*/
`timescale 1ns/100ps

module v_blank_gen (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             hs,
	input  logic             vs,
	input  logic             vbl,
	input  logic             lace,
	input  logic             field1,
	input  logic             hbl,
	input  logic             hcnt_zero_line,
	input  geom_pkg::coord_t vbl_t,
	input  geom_pkg::coord_t vbl_b,
	output logic             hde,
	output logic             vde,
	output logic             vblank,
	output geom_pkg::coord_t vcnt,
	output logic             line_one,
	output geom_pkg::coord_t vsize
);

	logic             old_vs, old_vblank, old_hbl;
	logic             blank_rise, blank_fall;
	logic             even_field;
	logic             line_eval;
	logic             svbl, fvbl;
	geom_pkg::coord_t vend, vmax, vs_end;
	geom_pkg::coord_t f1_vend, f1_vsize;
	geom_pkg::coord_t bot_line;

	assign vblank     = vbl | ~vs;
	assign vde        = ~(fvbl | svbl);
	assign blank_rise = ~old_vblank & vblank;
	assign blank_fall = old_vblank & ~vblank;
	assign even_field = ~lace | ~field1;  // progressive counts as even
	assign line_eval  = (old_hbl & ~hbl) | (vcnt == geom_pkg::coord_rst);

	// negative bottom margin is relative to the frame end
	assign bot_line = vbl_b[11] ? vmax + vbl_b : vbl_b;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs     <= 1'b1;
			old_vblank <= 1'b0;
			old_hbl    <= 1'b1;
			vcnt       <= geom_pkg::coord_rst;
			vend       <= geom_pkg::coord_rst;
			vmax       <= geom_pkg::coord_rst;
			vs_end     <= geom_pkg::coord_rst;
			f1_vend    <= geom_pkg::coord_rst;
			f1_vsize   <= geom_pkg::coord_rst;
			vsize      <= geom_pkg::coord_rst;
			svbl       <= 1'b1;
			fvbl       <= 1'b1;
			hde        <= 1'b0;
			line_one   <= 1'b0;
		end else begin
			old_vs     <= vs;
			old_vblank <= vblank;
			old_hbl    <= hbl;

			if (hcnt_zero_line) vcnt <= vcnt + 12'd1;
			if (blank_rise)     vcnt <= geom_pkg::coord_rst;

			if (even_field) begin
				if (blank_fall)   vend   <= vcnt;
				if (~old_vs & vs) vs_end <= vcnt;
				if (blank_rise) begin
					vmax     <= vcnt;
					vsize    <= vcnt - vend + f1_vsize;
					f1_vsize <= geom_pkg::coord_rst;
				end
			end else begin
				// odd field, height kept for the next even field
				if (blank_fall) f1_vend  <= vcnt;
				if (blank_rise) f1_vsize <= vcnt - f1_vend;
			end

			if (line_eval) begin
				if (vcnt == vend + vbl_t) svbl <= 1'b0;
				if (vcnt == bot_line)     svbl <= 1'b1;

				if (vcnt == vmax - 12'd1)   fvbl <= 1'b1;
				if (vcnt == vs_end + 12'd2) fvbl <= 1'b0;
			end

			hde      <= ~hbl;
			line_one <= (vcnt == 12'd1);
		end
	end

	// line step from the horizontal side only while sync is low
	line_step_in_sync: assert property (@(posedge clk_sys) disable iff (reset)
		hcnt_zero_line |-> !hs);

	// first blank line with no margins keeps the picture off
	blank_keeps_vde_low: assert property (@(posedge clk_sys) disable iff (reset)
		(vblank && $past(vblank) && $past(vblank, 2) && vcnt == geom_pkg::coord_rst &&
		 vbl_t == geom_pkg::coord_rst && $past(vbl_b) == geom_pkg::coord_rst &&
		 vbl_b == geom_pkg::coord_rst) |-> !vde);

endmodule

//--- src/screen_info.sv
/*
	screen info snapshot
	latches margins, geometry and resolution at the end of each vertical
	blank and steps a wrapping counter whenever the geometry changed
*/
`timescale 1ns/100ps

module screen_info (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             vblank,
	input  geom_pkg::res_t   res,
	input  geom_pkg::coord_t hsize,
	input  geom_pkg::coord_t vsize,
	input  geom_pkg::coord_t hbl_l,
	input  geom_pkg::coord_t hbl_r,
	input  geom_pkg::coord_t vbl_t,
	input  geom_pkg::coord_t vbl_b,
	output geom_pkg::coord_t scr_hbl_l,
	output geom_pkg::coord_t scr_hbl_r,
	output geom_pkg::coord_t scr_vbl_t,
	output geom_pkg::coord_t scr_vbl_b,
	output geom_pkg::coord_t scr_hsize,
	output geom_pkg::coord_t scr_vsize,
	output geom_pkg::res_t   scr_res,
	output geom_pkg::flag_t  scr_flg
);

	logic old_vblank;
	logic snap;
	logic geom_diff;

	assign snap      = old_vblank & ~vblank;  // end of vertical blank
	assign geom_diff = (res != scr_res) || (hsize != scr_hsize) || (vsize != scr_vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vblank <= 1'b0;
			scr_hbl_l  <= geom_pkg::coord_rst;
			scr_hbl_r  <= geom_pkg::coord_rst;
			scr_vbl_t  <= geom_pkg::coord_rst;
			scr_vbl_b  <= geom_pkg::coord_rst;
			scr_hsize  <= geom_pkg::coord_rst;
			scr_vsize  <= geom_pkg::coord_rst;
			scr_res    <= geom_pkg::res_rst;
			scr_flg    <= geom_pkg::flag_rst;
		end else begin
			old_vblank <= vblank;
			if (snap) begin
				scr_hbl_l <= hbl_l;
				scr_hbl_r <= hbl_r;
				scr_vbl_t <= vbl_t;
				scr_vbl_b <= vbl_b;
				scr_hsize <= hsize;
				scr_vsize <= vsize;
				scr_res   <= res;
				if (geom_diff) scr_flg <= scr_flg + 7'd1;  // wraps
			end
		end
	end

	flg_only_at_snap: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(scr_flg) |-> ($past(vblank, 2) && !$past(vblank)));

endmodule

//--- src/blank_trim_top.sv
/*
	blanking trimmer top
	key decoder feeds the margins, horizontal and vertical blank
	generators measure the picture and form the display enables,
	and the snapshot register publishes the screen geometry
*/
`timescale 1ns/100ps

module blank_trim_top #(
	parameter int h_step       = 4,
	parameter int force_margin = 8,
	parameter int trim_lead    = 2
) (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                hs,
	input  logic                vs,
	input  logic                hblank,
	input  logic                vbl,
	input  logic                field1,
	input  logic                lace,
	input  geom_pkg::res_t      res,
	input  logic                kbd_level,
	input  geom_pkg::kbd_type_t kbd_type,
	input  geom_pkg::kbd_code_t kbd_data,
	input  logic                preset_load,
	input  geom_pkg::coord_t    preset_hbl_l,
	input  geom_pkg::coord_t    preset_hbl_r,
	input  geom_pkg::coord_t    preset_vbl_t,
	input  geom_pkg::coord_t    preset_vbl_b,
	output logic                hde,
	output logic                vde,
	output geom_pkg::coord_t    scr_hbl_l,
	output geom_pkg::coord_t    scr_hbl_r,
	output geom_pkg::coord_t    scr_vbl_t,
	output geom_pkg::coord_t    scr_vbl_b,
	output geom_pkg::coord_t    scr_hsize,
	output geom_pkg::coord_t    scr_vsize,
	output geom_pkg::res_t      scr_res,
	output geom_pkg::flag_t     scr_flg
);

	geom_pkg::coord_t hbl_l, hbl_r, vbl_t, vbl_b;
	geom_pkg::coord_t hsize, vsize;
	logic             hbl, hcnt_zero_line;
	logic             vblank, line_one;

	trim_keys #(.h_step(h_step)) u_trim_keys (
		.clk_sys(clk_sys), .reset(reset),
		.kbd_level(kbd_level), .kbd_type(kbd_type), .kbd_data(kbd_data),
		.preset_load(preset_load),
		.preset_hbl_l(preset_hbl_l), .preset_hbl_r(preset_hbl_r),
		.preset_vbl_t(preset_vbl_t), .preset_vbl_b(preset_vbl_b),
		.hbl_l(hbl_l), .hbl_r(hbl_r), .vbl_t(vbl_t), .vbl_b(vbl_b)
	);

	h_blank_gen #(.force_margin(force_margin), .trim_lead(trim_lead)) u_h_blank_gen (
		.clk_sys(clk_sys), .reset(reset),
		.hs(hs), .hblank(hblank), .field1(field1), .line_one(line_one),
		.hbl_l(hbl_l), .hbl_r(hbl_r),
		.hbl(hbl), .hcnt_zero_line(hcnt_zero_line), .hsize(hsize)
	);

	v_blank_gen u_v_blank_gen (
		.clk_sys(clk_sys), .reset(reset),
		.hs(hs), .vs(vs), .vbl(vbl), .lace(lace), .field1(field1),
		.hbl(hbl), .hcnt_zero_line(hcnt_zero_line),
		.vbl_t(vbl_t), .vbl_b(vbl_b),
		.hde(hde), .vde(vde), .vblank(vblank), .vcnt(),
		.line_one(line_one), .vsize(vsize)
	);

	screen_info u_screen_info (
		.clk_sys(clk_sys), .reset(reset),
		.vblank(vblank), .res(res), .hsize(hsize), .vsize(vsize),
		.hbl_l(hbl_l), .hbl_r(hbl_r), .vbl_t(vbl_t), .vbl_b(vbl_b),
		.scr_hbl_l(scr_hbl_l), .scr_hbl_r(scr_hbl_r),
		.scr_vbl_t(scr_vbl_t), .scr_vbl_b(scr_vbl_b),
		.scr_hsize(scr_hsize), .scr_vsize(scr_vsize),
		.scr_res(scr_res), .scr_flg(scr_flg)
	);

endmodule

//--- testbench/tb_video_src.svh
/*
	video source tasks
	clock steps with display enable counting, single video lines,
	whole progressive frames and keyboard events
*/

// one clock, inputs change 1 ns after the edge
task automatic step_clk();
	@(posedge clk_sys);
	#1;
	if (hde) hde_seen = hde_seen + 1;  // post-edge value, stable here
endtask

// one line: sync low at the start, active video from act_sta to act_end
task automatic drive_line(input int len, input int sync_w, input int act_sta,
		input int act_end, input logic vbl_v, input logic vs_v);
	for (int j = 0; j < len; j++) begin
		step_clk();
		hs     = (j >= sync_w);
		hblank = !((j >= act_sta) && (j < act_end));
		vbl    = vbl_v;
		vs     = vs_v;
	end
endtask

// active lines first, then vertical blank with sync on two lines
task automatic drive_frame(input int lines, input int act_lines, input int width);
	logic blank_line;
	logic sync_line;
	for (int l = 0; l < lines; l++) begin
		blank_line = (l >= act_lines);
		sync_line  = (l == act_lines + 2) || (l == act_lines + 3);
		drive_line(line_len, sync_w, act_sta, act_sta + width, blank_line, !sync_line);
	end
endtask

// keyboard event, optionally with a preset strobe in the same cycle
task automatic send_key(input logic [7:0] code, input logic with_preset);
	step_clk();
	kbd_type    = geom_pkg::kbd_type_key;
	kbd_data    = code;
	kbd_level   = ~kbd_level;
	preset_load = with_preset;
	step_clk();
	preset_load = 1'b0;
	for (int i = 0; i < 3; i++)
		step_clk();  // margins settle two cycles after the toggle
endtask

// a few mid-frame lines, the display enable counted on the last one
task automatic count_hde_line(input int width, output int count);
	for (int i = 0; i < 3; i++)
		drive_line(line_len, sync_w, act_sta, act_sta + width, 1'b0, 1'b1);
	hde_seen = 0;
	drive_line(line_len, sync_w, act_sta, act_sta + width, 1'b0, 1'b1);
	count = hde_seen;
endtask

//--- testbench/tb_blank_trim.sv
/*
	blanking trimmer testbench
	drives sync, blank and key events into the top level and checks
	the screen snapshot, the change counter and the display enables
*/
`timescale 1ns/100ps

module tb_blank_trim;

	localparam int h_step    = 4;
	localparam int line_len  = 170;
	localparam int sync_w    = 8;
	localparam int act_sta   = 24;
	localparam int frm_lines = 20;
	localparam int act_lines = 12;

	logic                clk_sys = 1'b0;
	logic                reset   = 1'b1;
	logic                hs, vs, hblank, vbl, field1, lace;
	geom_pkg::res_t      res;
	logic                kbd_level, preset_load;
	geom_pkg::kbd_type_t kbd_type;
	geom_pkg::kbd_code_t kbd_data;
	geom_pkg::coord_t    preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b;
	logic                hde, vde;
	geom_pkg::coord_t    scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_vbl_b;
	geom_pkg::coord_t    scr_hsize, scr_vsize;
	geom_pkg::res_t      scr_res;
	geom_pkg::flag_t     scr_flg;

	int          hde_seen;
	int          test_errs, fail_tests, run_tests;
	int          width;
	logic [31:0] lfsr = 32'ha3f382d3;

	always #2 clk_sys = ~clk_sys;

	blank_trim_top #(.h_step(h_step), .force_margin(8), .trim_lead(2)) u_blank_trim_top (
		.clk_sys(clk_sys), .reset(reset),
		.hs(hs), .vs(vs), .hblank(hblank), .vbl(vbl), .field1(field1), .lace(lace),
		.res(res), .kbd_level(kbd_level), .kbd_type(kbd_type), .kbd_data(kbd_data),
		.preset_load(preset_load),
		.preset_hbl_l(preset_hbl_l), .preset_hbl_r(preset_hbl_r),
		.preset_vbl_t(preset_vbl_t), .preset_vbl_b(preset_vbl_b),
		.hde(hde), .vde(vde),
		.scr_hbl_l(scr_hbl_l), .scr_hbl_r(scr_hbl_r),
		.scr_vbl_t(scr_vbl_t), .scr_vbl_b(scr_vbl_b),
		.scr_hsize(scr_hsize), .scr_vsize(scr_vsize),
		.scr_res(scr_res), .scr_flg(scr_flg)
	);

	`include "tb_video_src.svh"

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("error %s: expected %0d, actual %0d", name, exp, act);
			test_errs = test_errs + 1;
		end
	endtask

	task automatic end_test(input string name);
		run_tests = run_tests + 1;
		if (test_errs != 0) fail_tests = fail_tests + 1;
		$display("test %s finished with %0d mismatches", name, test_errs);
		test_errs = 0;
	endtask

	task automatic run_frame();
		drive_frame(frm_lines, act_lines, width);
	endtask

	task automatic reset_values();
		compare("reset hde", 0, hde);
		compare("reset vde", 0, vde);
		compare("reset scr_flg", 0, scr_flg);
		compare("reset scr_hbl_l", 0, scr_hbl_l);
		compare("reset scr_hbl_r", 0, scr_hbl_r);
		compare("reset scr_vbl_t", 0, scr_vbl_t);
		compare("reset scr_vbl_b", 0, scr_vbl_b);
		compare("reset scr_hsize", 0, scr_hsize);
		compare("reset scr_vsize", 0, scr_vsize);
		compare("reset scr_res", 0, scr_res);
		end_test("reset");
	endtask

	task automatic measure_geometry();
		res = 2'd2;
		rand_bits(6, width);
		width = width + 64;
		run_frame();
		run_frame();  // snapshot holds the previous frame's geometry
		compare("measure hsize", width, scr_hsize);
		compare("measure vsize", act_lines, scr_vsize);
		compare("measure res", 2, scr_res);
		end_test("measurement");
	endtask

	task automatic key_trims();
		send_key(geom_pkg::key_up, 1'b0);
		run_frame();
		compare("keys up vbl_t", 1, scr_vbl_t);
		send_key(geom_pkg::key_alt_press_l, 1'b0);
		send_key(geom_pkg::key_left, 1'b0);
		run_frame();
		compare("keys alt left hbl_r", h_step, scr_hbl_r);
		compare("keys alt left hbl_l", 0, scr_hbl_l);
		send_key(geom_pkg::key_alt_rel_l, 1'b0);
		send_key(geom_pkg::key_down, 1'b0);
		run_frame();
		compare("keys down vbl_t", 0, scr_vbl_t);
		// every margin away from zero before the clear
		send_key(geom_pkg::key_left, 1'b0);
		send_key(geom_pkg::key_up, 1'b0);
		send_key(geom_pkg::key_alt_press_r, 1'b0);
		send_key(geom_pkg::key_up, 1'b0);
		send_key(geom_pkg::key_alt_rel_r, 1'b0);
		send_key(geom_pkg::key_backspace, 1'b0);
		run_frame();
		compare("keys clear hbl_l", 0, scr_hbl_l);
		compare("keys clear hbl_r", 0, scr_hbl_r);
		compare("keys clear vbl_t", 0, scr_vbl_t);
		compare("keys clear vbl_b", 0, scr_vbl_b);
		end_test("key trims");
	endtask

	task automatic change_counter();
		geom_pkg::flag_t base;
		int              new_w;
		base = scr_flg;
		run_frame();
		compare("flag same frame", base, scr_flg);
		res = 2'd1;
		run_frame();
		compare("flag res change", base + 7'd1, scr_flg);
		rand_bits(6, new_w);
		new_w = new_w + 64;
		if (new_w == width) new_w = new_w ^ 1;
		width = new_w;
		run_frame();  // width measured in this frame's blank
		run_frame();
		compare("flag width change", base + 7'd2, scr_flg);
		compare("flag new hsize", width, scr_hsize);
		run_frame();
		compare("flag stable again", base + 7'd2, scr_flg);
		end_test("change counter");
	endtask

	task automatic preset_priority();
		preset_hbl_l = 12'd8;
		preset_hbl_r = 12'd12;
		preset_vbl_t = 12'd2;
		preset_vbl_b = 12'd3;
		send_key(geom_pkg::key_up, 1'b1);
		run_frame();
		compare("preset hbl_l", 8, scr_hbl_l);
		compare("preset hbl_r", 12, scr_hbl_r);
		compare("preset vbl_t", 2, scr_vbl_t);
		compare("preset vbl_b", 3, scr_vbl_b);
		end_test("preset");
	endtask

	task automatic display_enable();
		int count;
		send_key(geom_pkg::key_backspace, 1'b0);
		count_hde_line(width, count);
		compare("hde zero margins", width, count);
		send_key(geom_pkg::key_left, 1'b0);
		count_hde_line(width, count);
		compare("hde left trim", width - h_step, count);
		end_test("display enable");
	endtask

	initial begin
		hs           = 1'b1;
		vs           = 1'b1;
		hblank       = 1'b1;
		vbl          = 1'b1;
		field1       = 1'b0;
		lace         = 1'b0;
		res          = 2'd0;
		kbd_level    = 1'b0;
		kbd_type     = 2'd0;
		kbd_data     = 8'd0;
		preset_load  = 1'b0;
		preset_hbl_l = 12'd0;
		preset_hbl_r = 12'd0;
		preset_vbl_t = 12'd0;
		preset_vbl_b = 12'd0;
		hde_seen     = 0;
		test_errs    = 0;
		fail_tests   = 0;
		run_tests    = 0;
		width        = 64;
		repeat (3) @(posedge clk_sys);
		#1 reset = 1'b0;
		step_clk();

		reset_values();
		measure_geometry();
		key_trims();
		change_counter();
		preset_priority();
		display_enable();

		$display("%0d tests run, %0d failed", run_tests, fail_tests);
		if (fail_tests == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- sim.f
common/geom_pkg.sv
src/trim_keys.sv
video/h_blank_gen.sv
video/v_blank_gen.sv
src/screen_info.sv
src/blank_trim_top.sv
+incdir+testbench
testbench/tb_blank_trim.sv

//--- run.sh
#!/bin/sh
# build and run the blanking trimmer simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
	-f sim.f \
	--top-module tb_blank_trim \
	-o sim_blank_trim

./obj_dir/sim_blank_trim > sim.log 2>&1 || true
cat sim.log

# pass only if the testbench printed its pass line
grep -qx "all tests passed" sim.log
